//--- rtl/intra4_pkg.sv
package intra4_pkg;

    // Macroblock geometry
    localparam int N_BLK   = 16;
    localparam int BLK_DIM = 4;
    localparam int MB_DIM  = 16;
    localparam int N_MODES = 4;

    typedef logic [7:0]    pixel_t;
    typedef logic [31:0]   row_t;
    typedef logic [127:0]  blk_t;
    typedef logic [2047:0] mb_t;
    typedef logic [127:0]  mbedge_t;
    typedef logic [3:0]    blk_idx_t;

    // Score widths
    typedef logic [19:0] sse_t;
    typedef logic [15:0] lambda_t;
    typedef logic [10:0] cost_t;
    typedef logic [31:0] score_t;
    typedef logic [35:0] mb_score_t;

    // Index order is also the tie-break order
    typedef enum logic [1:0] {
        MODE_DC = 2'd0,
        MODE_TM = 2'd1,
        MODE_VE = 2'd2,
        MODE_HE = 2'd3
    } mode_t;

    function automatic cost_t mode_cost(input mode_t m);
        case (m)
            MODE_DC: return 11'd40;
            MODE_TM: return 11'd1151;
            MODE_VE: return 11'd1723;
            default: return 11'd1874;
        endcase
    endfunction

endpackage

//--- rtl/intra4_pred.sv
`timescale 1ns/1ns

module intra4_pred import intra4_pkg::*; (
    input  row_t   ctx_top_i,
    input  row_t   ctx_left_i,
    input  pixel_t ctx_top_left_i,
    output blk_t   pred_dc_o,
    output blk_t   pred_tm_o,
    output blk_t   pred_ve_o,
    output blk_t   pred_he_o
);

    pixel_t      top  [BLK_DIM];
    pixel_t      left [BLK_DIM];
    logic [10:0] dc_sum;
    pixel_t      dc_val;

    always_comb begin
        for (int k = 0; k < BLK_DIM; k++) begin
            top[k]  = ctx_top_i[8*k +: 8];
            left[k] = ctx_left_i[8*k +: 8];
        end
    end

    // DC: eight neighbours, rounded
    always_comb begin
        dc_sum = 11'd4;
        for (int k = 0; k < BLK_DIM; k++) begin
            dc_sum = dc_sum + 11'(top[k]) + 11'(left[k]);
        end
    end

    assign dc_val = dc_sum[10:3];

    //----------------------------------------------------------------------
    // Per pixel fill
    //----------------------------------------------------------------------
    always_comb begin : fill
        logic signed [9:0] tm;
        for (int y = 0; y < BLK_DIM; y++) begin
            for (int x = 0; x < BLK_DIM; x++) begin
                pred_dc_o[8*(BLK_DIM*y+x) +: 8] = dc_val;
                pred_ve_o[8*(BLK_DIM*y+x) +: 8] = top[x];
                pred_he_o[8*(BLK_DIM*y+x) +: 8] = left[y];
                tm = $signed({2'b00, left[y]}) + $signed({2'b00, top[x]})
                   - $signed({2'b00, ctx_top_left_i});
                // Clip to pixel range
                if (tm < 0) begin
                    pred_tm_o[8*(BLK_DIM*y+x) +: 8] = 8'd0;
                end else if (tm > 10'sd255) begin
                    pred_tm_o[8*(BLK_DIM*y+x) +: 8] = 8'd255;
                end else begin
                    pred_tm_o[8*(BLK_DIM*y+x) +: 8] = tm[7:0];
                end
            end
        end
    end

endmodule

//--- rtl/intra4_sse.sv
`timescale 1ns/1ns

module intra4_sse import intra4_pkg::*; (
    input  logic clk,
    input  logic rst_n,
    input  logic sse_start_i,
    input  blk_t src_blk_i,
    input  blk_t pred_dc_i,
    input  blk_t pred_tm_i,
    input  blk_t pred_ve_i,
    input  blk_t pred_he_i,
    output sse_t sse_dc_o,
    output sse_t sse_tm_o,
    output sse_t sse_ve_o,
    output sse_t sse_he_o,
    output logic sse_done_o
);

    blk_t       pred [N_MODES];
    sse_t       acc  [N_MODES];
    logic [1:0] row_cnt;
    logic       active;
    row_t       src_row;

    function automatic sse_t row_sse(input row_t a, input row_t b);
        logic signed [8:0] d;
        logic [17:0]       sq;
        sse_t              sum;
        sum = '0;
        for (int x = 0; x < BLK_DIM; x++) begin
            d   = $signed({1'b0, a[8*x +: 8]}) - $signed({1'b0, b[8*x +: 8]});
            sq  = d * d;
            sum = sum + sse_t'(sq);
        end
        return sum;
    endfunction

    assign pred[0] = pred_dc_i;
    assign pred[1] = pred_tm_i;
    assign pred[2] = pred_ve_i;
    assign pred[3] = pred_he_i;

    // Counter sits at zero between walks
    assign src_row = src_blk_i[32*row_cnt +: 32];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            row_cnt    <= 2'd0;
            active     <= 1'b0;
            sse_done_o <= 1'b0;
        end else begin
            sse_done_o <= 1'b0;
            if (sse_start_i || active) begin
                row_cnt <= row_cnt + 2'd1;
                active  <= (row_cnt != 2'd3);
                if (row_cnt == 2'd3) begin
                    sse_done_o <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int m = 0; m < N_MODES; m++) begin
            if (sse_start_i) begin
                acc[m] <= row_sse(src_row, pred[m][32*row_cnt +: 32]);
            end else if (active) begin
                acc[m] <= acc[m] + row_sse(src_row, pred[m][32*row_cnt +: 32]);
            end
        end
    end

    assign sse_dc_o = acc[0];
    assign sse_tm_o = acc[1];
    assign sse_ve_o = acc[2];
    assign sse_he_o = acc[3];

    a_no_restart: assert property (@(posedge clk) disable iff (!rst_n)
        !(sse_start_i && active));

endmodule

//--- rtl/intra4_pick.sv
`timescale 1ns/1ns

module intra4_pick import intra4_pkg::*; (
    input  sse_t    sse_dc_i,
    input  sse_t    sse_tm_i,
    input  sse_t    sse_ve_i,
    input  sse_t    sse_he_i,
    input  lambda_t lambda_i,
    output mode_t   best_mode_o,
    output score_t  best_score_o
);

    sse_t   sse   [N_MODES];
    score_t score [N_MODES];

    assign sse[0] = sse_dc_i;
    assign sse[1] = sse_tm_i;
    assign sse[2] = sse_ve_i;
    assign sse[3] = sse_he_i;

    // 256 * SSE + lambda * fixed cost
    always_comb begin
        for (int m = 0; m < N_MODES; m++) begin
            score[m] = score_t'({sse[m], 8'd0})
                     + score_t'(lambda_i) * score_t'(mode_cost(mode_t'(m)));
        end
    end

    // Strict compare keeps the lower index on a tie
    always_comb begin
        best_mode_o  = MODE_DC;
        best_score_o = score[0];
        for (int m = 1; m < N_MODES; m++) begin
            if (score[m] < best_score_o) begin
                best_mode_o  = mode_t'(m);
                best_score_o = score[m];
            end
        end
    end

endmodule

//--- rtl/intra4_context.sv
`timescale 1ns/1ns

module intra4_context import intra4_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     ctx_load_i,
    input  logic     ctx_update_i,
    input  blk_idx_t blk_idx_i,
    input  blk_t     best_blk_i,
    input  mbedge_t  top_i,
    input  mbedge_t  left_i,
    input  pixel_t   top_left_i,
    output row_t     ctx_top_o,
    output row_t     ctx_left_o,
    output pixel_t   ctx_top_left_o
);

    mbedge_t    line_buf;
    row_t       right_col;
    pixel_t     corner;
    blk_idx_t   nxt_idx;
    logic [1:0] cur_c;
    logic [1:0] nxt_r;
    logic [1:0] nxt_c;

    assign cur_c = blk_idx_i[1:0];
    assign nxt_r = nxt_idx[3:2];
    assign nxt_c = nxt_idx[1:0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            nxt_idx <= '0;
        end else if (ctx_load_i) begin
            nxt_idx <= '0;
        end else if (ctx_update_i) begin
            nxt_idx <= blk_idx_i + 4'd1;
        end
    end

    //----------------------------------------------------------------------
    // Line buffer, last right column, saved corner
    //----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (ctx_load_i) begin
            line_buf <= top_i;
        end else if (ctx_update_i) begin
            // Bottom row replaces this column's slot
            line_buf[8*BLK_DIM*cur_c +: 32] <= best_blk_i[96 +: 32];
            right_col <= {best_blk_i[8*15 +: 8], best_blk_i[8*11 +: 8],
                          best_blk_i[8*7 +: 8], best_blk_i[8*3 +: 8]};
            // Old pixel 4c+3, corner of the block to the right
            corner    <= line_buf[8*(BLK_DIM*cur_c + 3) +: 8];
        end
    end

    // Context for the block about to be processed
    always_comb begin
        ctx_top_o = line_buf[8*BLK_DIM*nxt_c +: 32];
        if (nxt_c == 2'd0) begin
            ctx_left_o = left_i[8*BLK_DIM*nxt_r +: 32];
        end else begin
            ctx_left_o = right_col;
        end
        if (nxt_idx == '0) begin
            ctx_top_left_o = top_left_i;
        end else if (nxt_c == 2'd0) begin
            ctx_top_left_o = left_i[8*(BLK_DIM*nxt_r - 1) +: 8];
        end else begin
            ctx_top_left_o = corner;
        end
    end

    a_load_xor_update: assert property (@(posedge clk) disable iff (!rst_n)
        !(ctx_load_i && ctx_update_i));

endmodule

//--- rtl/intra4_ctrl.sv
`timescale 1ns/1ns

module intra4_ctrl import intra4_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        start_i,
    input  mb_t         ysrc_i,
    input  logic        sse_done_i,
    input  mode_t       best_mode_i,
    input  score_t      best_score_i,
    input  blk_t        pred_dc_i,
    input  blk_t        pred_tm_i,
    input  blk_t        pred_ve_i,
    input  blk_t        pred_he_i,
    output logic        ctx_load_o,
    output logic        ctx_update_o,
    output blk_idx_t    blk_idx_o,
    output blk_t        src_blk_o,
    output blk_t        best_blk_o,
    output logic        sse_start_o,
    output mb_t         yout_o,
    output logic [31:0] mode_o,
    output mb_score_t   score_o,
    output logic        busy_o,
    output logic        done_o
);

    typedef enum logic [2:0] {
        IDLE,
        LOAD,
        RUN,
        WAIT_SSE,
        STORE,
        NEXT,
        DONE
    } state_t;

    state_t     state;
    mode_t      mode_r;
    score_t     blk_score_r;
    logic [1:0] blk_r;
    logic [1:0] blk_c;
    logic       last_blk;

    assign blk_r    = blk_idx_o[3:2];
    assign blk_c    = blk_idx_o[1:0];
    assign last_blk = (blk_idx_o == blk_idx_t'(N_BLK - 1));

    //----------------------------------------------------------------------
    // Block sequencing FSM
    //----------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= IDLE;
            blk_idx_o <= '0;
        end else begin
            case (state)
                IDLE:     if (start_i) state <= LOAD;
                LOAD: begin
                    blk_idx_o <= '0;
                    state     <= RUN;
                end
                RUN:      state <= WAIT_SSE;
                WAIT_SSE: if (sse_done_i) state <= STORE;
                STORE:    state <= NEXT;
                NEXT: begin
                    if (last_blk) begin
                        state <= DONE;
                    end else begin
                        blk_idx_o <= blk_idx_o + 4'd1;
                        state     <= RUN;
                    end
                end
                default:  state <= IDLE;
            endcase
        end
    end

    assign ctx_load_o   = (state == LOAD);
    assign sse_start_o  = (state == RUN);
    assign ctx_update_o = (state == STORE);
    assign done_o       = (state == DONE);

    // Busy from accepted start until the last block is stored
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_o <= 1'b0;
        end else if (state == IDLE && start_i) begin
            busy_o <= 1'b1;
        end else if (state == NEXT && last_blk) begin
            busy_o <= 1'b0;
        end
    end

    // Winner of the current block
    always_ff @(posedge clk) begin
        if (state == WAIT_SSE && sse_done_i) begin
            mode_r      <= best_mode_i;
            blk_score_r <= best_score_i;
        end
    end

    always_comb begin
        case (mode_r)
            MODE_TM: best_blk_o = pred_tm_i;
            MODE_VE: best_blk_o = pred_ve_i;
            MODE_HE: best_blk_o = pred_he_i;
            default: best_blk_o = pred_dc_i;
        endcase
    end

    // Source block gathered row by row from the macroblock
    always_comb begin
        for (int y = 0; y < BLK_DIM; y++) begin
            src_blk_o[32*y +: 32] =
                ysrc_i[8*((BLK_DIM*blk_r + y)*MB_DIM + BLK_DIM*blk_c) +: 32];
        end
    end

    //----------------------------------------------------------------------
    // Result storage
    //----------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            yout_o  <= '0;
            mode_o  <= '0;
            score_o <= '0;
        end else if (state == LOAD) begin
            score_o <= '0;
        end else if (state == STORE) begin
            for (int y = 0; y < BLK_DIM; y++) begin
                yout_o[8*((BLK_DIM*blk_r + y)*MB_DIM + BLK_DIM*blk_c) +: 32] <=
                    best_blk_o[32*y +: 32];
            end
            mode_o[2*blk_idx_o +: 2] <= mode_r;
            score_o <= score_o + mb_score_t'(blk_score_r);
        end
    end

    a_done_not_busy: assert property (@(posedge clk) disable iff (!rst_n)
        !(done_o && busy_o));

    a_sse_in_wait: assert property (@(posedge clk) disable iff (!rst_n)
        sse_done_i |-> state == WAIT_SSE);

endmodule

//--- rtl/intra4_picker.sv
`timescale 1ns/1ns

module intra4_picker import intra4_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        start_i,
    input  lambda_t     lambda_i,
    input  mb_t         ysrc_i,
    input  mbedge_t     top_i,
    input  mbedge_t     left_i,
    input  pixel_t      top_left_i,
    output mb_t         yout_o,
    output logic [31:0] mode_o,
    output mb_score_t   score_o,
    output logic        busy_o,
    output logic        done_o
);

    logic     ctx_load;
    logic     ctx_update;
    blk_idx_t blk_idx;
    blk_t     src_blk;
    blk_t     best_blk;
    logic     sse_start;
    logic     sse_done;
    row_t     ctx_top;
    row_t     ctx_left;
    pixel_t   ctx_top_left;
    blk_t     pred_dc;
    blk_t     pred_tm;
    blk_t     pred_ve;
    blk_t     pred_he;
    sse_t     sse_dc;
    sse_t     sse_tm;
    sse_t     sse_ve;
    sse_t     sse_he;
    mode_t    best_mode;
    score_t   best_score;

    intra4_ctrl intra4_ctrl_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .start_i      (start_i),
        .ysrc_i       (ysrc_i),
        .sse_done_i   (sse_done),
        .best_mode_i  (best_mode),
        .best_score_i (best_score),
        .pred_dc_i    (pred_dc),
        .pred_tm_i    (pred_tm),
        .pred_ve_i    (pred_ve),
        .pred_he_i    (pred_he),
        .ctx_load_o   (ctx_load),
        .ctx_update_o (ctx_update),
        .blk_idx_o    (blk_idx),
        .src_blk_o    (src_blk),
        .best_blk_o   (best_blk),
        .sse_start_o  (sse_start),
        .yout_o       (yout_o),
        .mode_o       (mode_o),
        .score_o      (score_o),
        .busy_o       (busy_o),
        .done_o       (done_o)
    );

    intra4_context intra4_context_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .ctx_load_i     (ctx_load),
        .ctx_update_i   (ctx_update),
        .blk_idx_i      (blk_idx),
        .best_blk_i     (best_blk),
        .top_i          (top_i),
        .left_i         (left_i),
        .top_left_i     (top_left_i),
        .ctx_top_o      (ctx_top),
        .ctx_left_o     (ctx_left),
        .ctx_top_left_o (ctx_top_left)
    );

    intra4_pred intra4_pred_inst (
        .ctx_top_i      (ctx_top),
        .ctx_left_i     (ctx_left),
        .ctx_top_left_i (ctx_top_left),
        .pred_dc_o      (pred_dc),
        .pred_tm_o      (pred_tm),
        .pred_ve_o      (pred_ve),
        .pred_he_o      (pred_he)
    );

    intra4_sse intra4_sse_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .sse_start_i (sse_start),
        .src_blk_i   (src_blk),
        .pred_dc_i   (pred_dc),
        .pred_tm_i   (pred_tm),
        .pred_ve_i   (pred_ve),
        .pred_he_i   (pred_he),
        .sse_dc_o    (sse_dc),
        .sse_tm_o    (sse_tm),
        .sse_ve_o    (sse_ve),
        .sse_he_o    (sse_he),
        .sse_done_o  (sse_done)
    );

    intra4_pick intra4_pick_inst (
        .sse_dc_i     (sse_dc),
        .sse_tm_i     (sse_tm),
        .sse_ve_i     (sse_ve),
        .sse_he_i     (sse_he),
        .lambda_i     (lambda_i),
        .best_mode_o  (best_mode),
        .best_score_o (best_score)
    );

endmodule

//--- dv/intra4_model.svh
`ifndef INTRA4_MODEL_SVH
`define INTRA4_MODEL_SVH

// Expected results of the last modelled macroblock
mb_t         exp_yout;
logic [31:0] exp_mode;
mb_score_t   exp_score;

// Reconstructed picture, row 0 and column 0 hold the border pixels
int pic [17][17];

function automatic longint fixed_cost(input int m);
    case (m)
        0: return 40;
        1: return 1151;
        2: return 1723;
        default: return 1874;
    endcase
endfunction

function automatic int clip_pixel(input int v);
    if (v < 0) begin
        return 0;
    end
    if (v > 255) begin
        return 255;
    end
    return v;
endfunction

//----------------------------------------------------------------------
// Raster walk over the sixteen blocks
//----------------------------------------------------------------------
task automatic model_mb(input mb_t src, input mbedge_t top, input mbedge_t left,
                        input pixel_t tl, input lambda_t lam);
    int     r;
    int     c;
    int     dc;
    int     best;
    int     d;
    int     corner;
    int     tp [4];
    int     lf [4];
    int     cand [4][16];
    longint sse;
    longint score;
    longint best_score;
    longint total;
    pic[0][0] = tl;
    for (int i = 0; i < MB_DIM; i++) begin
        pic[0][i+1] = top[8*i +: 8];
        pic[i+1][0] = left[8*i +: 8];
    end
    total = 0;
    exp_mode = '0;
    exp_yout = '0;
    for (int b = 0; b < N_BLK; b++) begin
        r = b / 4;
        c = b % 4;
        corner = pic[4*r][4*c];
        dc = 4;
        for (int k = 0; k < BLK_DIM; k++) begin
            tp[k] = pic[4*r][4*c+1+k];
            lf[k] = pic[4*r+1+k][4*c];
            dc = dc + tp[k] + lf[k];
        end
        dc = dc / 8;
        for (int i = 0; i < 16; i++) begin
            cand[0][i] = dc;
            cand[1][i] = clip_pixel(lf[i/4] + tp[i%4] - corner);
            cand[2][i] = tp[i%4];
            cand[3][i] = lf[i/4];
        end
        best = 0;
        best_score = 0;
        for (int m = 0; m < N_MODES; m++) begin
            sse = 0;
            for (int i = 0; i < 16; i++) begin
                d = cand[m][i] - int'(src[8*((4*r + i/4)*MB_DIM + 4*c + i%4) +: 8]);
                sse = sse + d * d;
            end
            score = 256 * sse + longint'(lam) * fixed_cost(m);
            // Lower index keeps a tie
            if (m == 0 || score < best_score) begin
                best = m;
                best_score = score;
            end
        end
        for (int i = 0; i < 16; i++) begin
            pic[4*r+1+i/4][4*c+1+i%4] = cand[best][i];
            exp_yout[8*((4*r + i/4)*MB_DIM + 4*c + i%4) +: 8] = cand[best][i][7:0];
        end
        exp_mode[2*b +: 2] = best[1:0];
        total = total + best_score;
    end
    exp_score = total[35:0];
endtask

`endif

//--- dv/tb_intra4_picker.sv
`timescale 1ns/1ns

module tb_intra4_picker import intra4_pkg::*; ();

    localparam int     N_RUNS     = 6;
    localparam int     MAX_CYCLES = N_RUNS * 150;
    localparam pixel_t FLAT       = 8'd128;

    logic        clk;
    logic        rst_n;
    logic        start_i;
    lambda_t     lambda_i;
    mb_t         ysrc_i;
    mbedge_t     top_i;
    mbedge_t     left_i;
    pixel_t      top_left_i;
    mb_t         yout_o;
    logic [31:0] mode_o;
    mb_score_t   score_o;
    logic        busy_o;
    logic        done_o;

    int   value_errs;
    int   ctrl_errs;
    int   cycles;
    int   starts;
    int   dones;
    logic expect_dc;
    logic expect_copy;

    `include "intra4_model.svh"

    intra4_picker intra4_picker_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .start_i    (start_i),
        .lambda_i   (lambda_i),
        .ysrc_i     (ysrc_i),
        .top_i      (top_i),
        .left_i     (left_i),
        .top_left_i (top_left_i),
        .yout_o     (yout_o),
        .mode_o     (mode_o),
        .score_o    (score_o),
        .busy_o     (busy_o),
        .done_o     (done_o)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (rst_n && done_o) begin
            dones <= dones + 1;
        end
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: run stopped after %0d cycles without finishing", cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    //----------------------------------------------------------------------
    // Result checks at done
    //----------------------------------------------------------------------
    a_mode: assert property (@(posedge clk) disable iff (!rst_n) done_o |-> mode_o == exp_mode)
        else begin
            value_errs++;
            $display("ERR %0t mode_o expected %h got %h", $time, exp_mode, mode_o);
        end
    a_score: assert property (@(posedge clk) disable iff (!rst_n)
        done_o |-> score_o == exp_score)
        else begin
            value_errs++;
            $display("ERR %0t score_o expected %0d got %0d", $time, exp_score, score_o);
        end
    a_yout: assert property (@(posedge clk) disable iff (!rst_n) done_o |-> yout_o == exp_yout)
        else begin
            value_errs++;
            $display("ERR %0t yout_o expected %h got %h", $time, exp_yout, yout_o);
        end
    a_all_dc: assert property (@(posedge clk) disable iff (!rst_n)
        done_o && expect_dc |-> mode_o == 32'h0)
        else begin
            value_errs++;
            $display("ERR %0t mode_o expected %h got %h", $time, 32'h0, mode_o);
        end
    a_copy_yout: assert property (@(posedge clk) disable iff (!rst_n)
        done_o && expect_copy |-> yout_o == ysrc_i)
        else begin
            value_errs++;
            $display("ERR %0t yout_o expected %h got %h", $time, ysrc_i, yout_o);
        end
    a_copy_score: assert property (@(posedge clk) disable iff (!rst_n)
        done_o && expect_copy |-> score_o == mb_score_t'(N_BLK * 100 * 40))
        else begin
            value_errs++;
            $display("ERR %0t score_o expected %0d got %0d", $time, N_BLK * 100 * 40, score_o);
        end

    // Control behaviour
    a_reset_quiet: assert property (@(posedge clk) $rose(rst_n) |->
        !busy_o && !done_o && yout_o == '0 && mode_o == '0 && score_o == '0)
        else begin
            ctrl_errs++;
            $display("Outputs were not quiet and zero when reset was released");
        end
    a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n) done_o |=> !done_o)
        else begin
            ctrl_errs++;
            $display("done_o stayed high for more than one cycle");
        end
    a_busy_fall: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(busy_o) |-> done_o)
        else begin
            ctrl_errs++;
            $display("busy_o fell without a done_o pulse");
        end
    a_done_idle: assert property (@(posedge clk) disable iff (!rst_n) done_o |-> !busy_o)
        else begin
            ctrl_errs++;
            $display("busy_o was still high during done_o");
        end
    a_accept: assert property (@(posedge clk) disable iff (!rst_n)
        !busy_o && !done_o && start_i |=> busy_o)
        else begin
            ctrl_errs++;
            $display("A start while idle did not make the design busy");
        end
    a_no_spurious: assert property (@(posedge clk) disable iff (!rst_n)
        !busy_o && !done_o && !start_i |=> !busy_o)
        else begin
            ctrl_errs++;
            $display("The design became busy without an accepted start");
        end
    // A restart would clear the running score
    a_busy_start: assert property (@(posedge clk) disable iff (!rst_n)
        busy_o && start_i |-> ##2 score_o >= $past(score_o, 2))
        else begin
            ctrl_errs++;
            $display("A start while busy restarted the macroblock");
        end
    a_hold: assert property (@(posedge clk) disable iff (!rst_n)
        !busy_o && !done_o |-> $stable(yout_o) && $stable(mode_o) && $stable(score_o))
        else begin
            ctrl_errs++;
            $display("Outputs changed while the design was idle");
        end

    //----------------------------------------------------------------------
    // Stimulus
    //----------------------------------------------------------------------
    function automatic mb_t random_mb();
        mb_t v;
        for (int i = 0; i < MB_DIM * MB_DIM; i++) begin
            v[8*i +: 8] = pixel_t'($urandom);
        end
        return v;
    endfunction

    function automatic mbedge_t random_edge();
        mbedge_t v;
        for (int i = 0; i < MB_DIM; i++) begin
            v[8*i +: 8] = pixel_t'($urandom);
        end
        return v;
    endfunction

    // Flat value with noise of at most one step
    function automatic mb_t noisy_mb(input pixel_t base);
        mb_t v;
        int  n;
        for (int i = 0; i < MB_DIM * MB_DIM; i++) begin
            n = int'(base) + int'($urandom % 3) - 1;
            v[8*i +: 8] = pixel_t'(n);
        end
        return v;
    endfunction

    function automatic mb_t stripe_mb(input mbedge_t vals, input bit vertical);
        mb_t v;
        for (int y = 0; y < MB_DIM; y++) begin
            for (int x = 0; x < MB_DIM; x++) begin
                v[8*(MB_DIM*y + x) +: 8] = vertical ? vals[8*x +: 8] : vals[8*y +: 8];
            end
        end
        return v;
    endfunction

    task automatic run_mb(input mb_t src, input mbedge_t top, input mbedge_t left,
                          input pixel_t tl, input lambda_t lam, input bit dc_only,
                          input bit copy, input bit stray);
        model_mb(src, top, left, tl, lam);
        expect_dc   = dc_only;
        expect_copy = copy;
        @(posedge clk);
        ysrc_i     <= src;
        top_i      <= top;
        left_i     <= left;
        top_left_i <= tl;
        lambda_i   <= lam;
        start_i    <= 1'b1;
        @(posedge clk);
        start_i <= 1'b0;
        starts++;
        if (stray) begin
            repeat (20) @(posedge clk);
            start_i <= 1'b1;
            @(posedge clk);
            start_i <= 1'b0;
        end
        @(negedge clk);
        while (done_o !== 1'b1) begin
            @(negedge clk);
        end
        // A few idle cycles so the held outputs get checked
        repeat (4) @(posedge clk);
    endtask

    initial begin
        mbedge_t stripes;
        void'($urandom(24153));
        rst_n       = 1'b0;
        start_i     = 1'b0;
        lambda_i    = '0;
        ysrc_i      = '0;
        top_i       = '0;
        left_i      = '0;
        top_left_i  = '0;
        value_errs  = 0;
        ctrl_errs   = 0;
        cycles      = 0;
        starts      = 0;
        dones       = 0;
        expect_dc   = 1'b0;
        expect_copy = 1'b0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        repeat (2) @(posedge clk);

        run_mb({256{FLAT}}, {16{FLAT}}, {16{FLAT}}, FLAT, 16'd100, 1'b1, 1'b1, 1'b0);
        // Pure SSE choice, with a start pulse while busy
        run_mb(random_mb(), random_edge(), random_edge(), pixel_t'($urandom), 16'd0,
               1'b0, 1'b0, 1'b1);
        run_mb(noisy_mb(FLAT), {16{FLAT}}, {16{FLAT}}, FLAT, 16'hffff, 1'b1, 1'b0, 1'b0);
        // Context rotation through chosen blocks
        run_mb(random_mb(), random_edge(), random_edge(), pixel_t'($urandom), 16'd40,
               1'b0, 1'b0, 1'b0);
        stripes = random_edge();
        run_mb(stripe_mb(stripes, 1'b1), stripes, random_edge(), pixel_t'($urandom), 16'd20,
               1'b0, 1'b0, 1'b0);
        stripes = random_edge();
        run_mb(stripe_mb(stripes, 1'b0), random_edge(), stripes, pixel_t'($urandom), 16'd20,
               1'b0, 1'b0, 1'b0);

        if (dones != starts) begin
            ctrl_errs++;
            $display("Saw %0d done pulses for %0d accepted starts", dones, starts);
        end
        $display("Errors: value %0d, control %0d", value_errs, ctrl_errs);
        if (value_errs == 0 && ctrl_errs == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- tb.f
+incdir+dv
rtl/intra4_pkg.sv
rtl/intra4_pred.sv
rtl/intra4_sse.sv
rtl/intra4_pick.sv
rtl/intra4_context.sv
rtl/intra4_ctrl.sv
rtl/intra4_picker.sv
dv/tb_intra4_picker.sv
